/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := credit_rd_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/cred_rd_consts.svh */
// Credit read path constants
`ifndef CRED_RD_CONSTS_SVH
`define CRED_RD_CONSTS_SVH

// Data beat width, 8 bytes per beat
`define CRED_DATA_BITS    64

// Request field widths
`define CRED_VADDR_BITS   32
`define CRED_LEN_BITS     16
`define CRED_PID_BITS     4

// Largest card packet in bytes
`define CRED_PKT_BYTES    32

// Packets allowed in flight
`define CRED_MAX_CREDITS  4

// Host request queue entries
`define CRED_REQ_QDEPTH   4

// Data FIFO beats, four full packets
`define CRED_DATA_DEPTH   16

`endif

/* common/cred_rd_pkg.sv */
// Credit read path types
`default_nettype none

`include "cred_rd_consts.svh"

package cred_rd_pkg;

    // Request splitter states
    typedef enum logic [0:0] {
        PARSE_IDLE,
        PARSE_SPLIT
    } parse_state_t;

    // Virtual address
    typedef logic [`CRED_VADDR_BITS-1:0] vaddr_t;

    // Byte length
    typedef logic [`CRED_LEN_BITS-1:0] len_t;

    // Process id
    typedef logic [`CRED_PID_BITS-1:0] pid_t;

endpackage

`default_nettype wire

/* logic/credit_rd_top.sv */
// Credit read path top
`default_nettype none

`include "cred_rd_consts.svh"

module credit_rd_top (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  s_req_valid,
    output logic                 s_req_ready,
    input  wire cred_rd_pkg::vaddr_t s_req_vaddr,
    input  wire cred_rd_pkg::len_t   s_req_len,
    input  wire cred_rd_pkg::pid_t   s_req_pid,

    output logic                 m_req_valid,
    input  wire                  m_req_ready,
    output cred_rd_pkg::vaddr_t  m_req_vaddr,
    output cred_rd_pkg::len_t    m_req_len,
    output cred_rd_pkg::pid_t    m_req_pid,
    output logic                 m_req_last,

    input  wire                  s_data_valid,
    output logic                 s_data_ready,
    input  wire [`CRED_DATA_BITS-1:0] s_data,
    input  wire                  s_data_last,

    output logic                 m_data_valid,
    input  wire                  m_data_ready,
    output logic [`CRED_DATA_BITS-1:0] m_data,
    output logic                 m_data_last,
    output cred_rd_pkg::pid_t    m_data_pid
);

    // Queue to parser
    logic                q_valid;
    logic                q_ready;
    cred_rd_pkg::vaddr_t q_vaddr;
    cred_rd_pkg::len_t   q_len;
    cred_rd_pkg::pid_t   q_pid;

    // Parser to credit gate
    logic                pkt_valid;
    logic                pkt_ready;
    cred_rd_pkg::vaddr_t pkt_vaddr;
    cred_rd_pkg::len_t   pkt_len;
    cred_rd_pkg::pid_t   pkt_pid;
    logic                pkt_last;

    // Credit gate to sequencer
    logic                cred_valid;
    logic                cred_ready;
    cred_rd_pkg::vaddr_t cred_vaddr;
    cred_rd_pkg::len_t   cred_len;
    cred_rd_pkg::pid_t   cred_pid;
    logic                cred_last;

    // Tagged data and credit return
    logic                       tag_valid;
    logic                       tag_ready;
    logic [`CRED_DATA_BITS-1:0] tag_data;
    logic                       tag_last;
    cred_rd_pkg::pid_t          tag_pid;
    logic                       pkt_done;

    req_queue inst_queue (
        .aclk(aclk), .rst_n(rst_n),
        .s_valid(s_req_valid), .s_ready(s_req_ready),
        .s_vaddr(s_req_vaddr), .s_len(s_req_len), .s_pid(s_req_pid),
        .m_valid(q_valid), .m_ready(q_ready),
        .m_vaddr(q_vaddr), .m_len(q_len), .m_pid(q_pid)
    );

    req_parser inst_parser (
        .aclk(aclk), .rst_n(rst_n),
        .s_valid(q_valid), .s_ready(q_ready),
        .s_vaddr(q_vaddr), .s_len(q_len), .s_pid(q_pid),
        .m_valid(pkt_valid), .m_ready(pkt_ready),
        .m_vaddr(pkt_vaddr), .m_len(pkt_len), .m_pid(pkt_pid), .m_last(pkt_last)
    );

    req_credits inst_credits (
        .aclk(aclk), .rst_n(rst_n),
        .s_valid(pkt_valid), .s_ready(pkt_ready),
        .s_vaddr(pkt_vaddr), .s_len(pkt_len), .s_pid(pkt_pid), .s_last(pkt_last),
        .m_valid(cred_valid), .m_ready(cred_ready),
        .m_vaddr(cred_vaddr), .m_len(cred_len), .m_pid(cred_pid), .m_last(cred_last),
        .pkt_done(pkt_done)
    );

    req_seq inst_seq (
        .aclk(aclk), .rst_n(rst_n),
        .s_valid(cred_valid), .s_ready(cred_ready),
        .s_vaddr(cred_vaddr), .s_len(cred_len), .s_pid(cred_pid), .s_last(cred_last),
        .m_req_valid(m_req_valid), .m_req_ready(m_req_ready),
        .m_req_vaddr(m_req_vaddr), .m_req_len(m_req_len),
        .m_req_pid(m_req_pid), .m_req_last(m_req_last),
        .s_data_valid(s_data_valid), .s_data_ready(s_data_ready),
        .s_data(s_data), .s_data_last(s_data_last),
        .tag_valid(tag_valid), .tag_ready(tag_ready),
        .tag_data(tag_data), .tag_last(tag_last), .tag_pid(tag_pid)
    );

    data_fifo inst_dq (
        .aclk(aclk), .rst_n(rst_n),
        .tag_valid(tag_valid), .tag_ready(tag_ready),
        .tag_data(tag_data), .tag_last(tag_last), .tag_pid(tag_pid),
        .m_data_valid(m_data_valid), .m_data_ready(m_data_ready),
        .m_data(m_data), .m_data_last(m_data_last), .m_data_pid(m_data_pid),
        .pkt_done(pkt_done)
    );

endmodule

`default_nettype wire

/* read_path/data_fifo.sv */
// Tagged read data buffer
`default_nettype none

`include "cred_rd_consts.svh"

module data_fifo (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  tag_valid,
    output logic                 tag_ready,
    input  wire [`CRED_DATA_BITS-1:0] tag_data,
    input  wire                  tag_last,
    input  wire cred_rd_pkg::pid_t   tag_pid,

    output logic                 m_data_valid,
    input  wire                  m_data_ready,
    output logic [`CRED_DATA_BITS-1:0] m_data,
    output logic                 m_data_last,
    output cred_rd_pkg::pid_t    m_data_pid,

    output logic                 pkt_done
);

    localparam int AW = $clog2(`CRED_DATA_DEPTH);

    // Input register stage
    logic                       in_valid;
    logic [`CRED_DATA_BITS-1:0] in_data;
    logic                       in_last;
    cred_rd_pkg::pid_t          in_pid;

    // Beat storage
    logic [`CRED_DATA_BITS-1:0] data_mem [`CRED_DATA_DEPTH];
    logic                       last_mem [`CRED_DATA_DEPTH];
    cred_rd_pkg::pid_t          pid_mem  [`CRED_DATA_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          fifo_full;
    logic          push;
    logic          pop;

    assign fifo_full = (count == (AW+1)'(`CRED_DATA_DEPTH));
    assign push      = in_valid && !fifo_full;

    // Register refills whenever it empties into storage
    assign tag_ready = !in_valid || !fifo_full;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
        end else if (tag_ready) begin
            in_valid <= tag_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (tag_valid && tag_ready) begin
            in_data <= tag_data;
            in_last <= tag_last;
            in_pid  <= tag_pid;
        end
    end

    assign m_data_valid = (count != '0);
    assign pop          = m_data_valid && m_data_ready;
    assign m_data       = data_mem[rd_ptr];
    assign m_data_last  = last_mem[rd_ptr];
    assign m_data_pid   = pid_mem[rd_ptr];

    // Credit back as a packet's last beat leaves
    assign pkt_done = pop && m_data_last;

    always_ff @(posedge aclk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
            pid_mem[wr_ptr]  <= in_pid;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* read_path/req_credits.sv */
// Packet credit gate
`default_nettype none

`include "cred_rd_consts.svh"

module req_credits (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  s_valid,
    output logic                 s_ready,
    input  wire cred_rd_pkg::vaddr_t s_vaddr,
    input  wire cred_rd_pkg::len_t   s_len,
    input  wire cred_rd_pkg::pid_t   s_pid,
    input  wire                  s_last,

    output logic                 m_valid,
    input  wire                  m_ready,
    output cred_rd_pkg::vaddr_t  m_vaddr,
    output cred_rd_pkg::len_t    m_len,
    output cred_rd_pkg::pid_t    m_pid,
    output logic                 m_last,

    input  wire                  pkt_done
);

    localparam int CW = $clog2(`CRED_MAX_CREDITS + 1);

    // Free packet slots
    logic [CW-1:0] credits;
    logic          have_credit;
    logic          issue;

    assign have_credit = (credits != '0);

    // Both sides blocked with no credit left
    assign m_valid = s_valid && have_credit;
    assign s_ready = m_ready && have_credit;
    assign issue   = m_valid && m_ready;

    assign m_vaddr = s_vaddr;
    assign m_len   = s_len;
    assign m_pid   = s_pid;
    assign m_last  = s_last;

    // Issue and return may coincide
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            credits <= CW'(`CRED_MAX_CREDITS);
        end else if (issue && !pkt_done) begin
            credits <= credits - 1'b1;
        end else if (!issue && pkt_done) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* read_path/req_parser.sv */
// Request splitter
`default_nettype none

`include "cred_rd_consts.svh"

module req_parser (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  s_valid,
    output logic                 s_ready,
    input  wire cred_rd_pkg::vaddr_t s_vaddr,
    input  wire cred_rd_pkg::len_t   s_len,
    input  wire cred_rd_pkg::pid_t   s_pid,

    output logic                 m_valid,
    input  wire                  m_ready,
    output cred_rd_pkg::vaddr_t  m_vaddr,
    output cred_rd_pkg::len_t    m_len,
    output cred_rd_pkg::pid_t    m_pid,
    output logic                 m_last
);

    localparam cred_rd_pkg::len_t   PKT_LEN  = cred_rd_pkg::len_t'(`CRED_PKT_BYTES);
    localparam cred_rd_pkg::vaddr_t PKT_STEP = cred_rd_pkg::vaddr_t'(`CRED_PKT_BYTES);

    cred_rd_pkg::parse_state_t state;

    // Request being split
    cred_rd_pkg::vaddr_t cur_vaddr;
    cred_rd_pkg::len_t   rem_len;
    cred_rd_pkg::pid_t   cur_pid;

    logic final_pkt;
    logic take;
    logic emit;

    // Remainder fits in one packet
    assign final_pkt = (rem_len <= PKT_LEN);

    assign s_ready = (state == cred_rd_pkg::PARSE_IDLE);
    assign m_valid = (state == cred_rd_pkg::PARSE_SPLIT);
    assign take    = s_valid && s_ready;
    assign emit    = m_valid && m_ready;

    assign m_vaddr = cur_vaddr;
    assign m_len   = final_pkt ? rem_len : PKT_LEN;
    assign m_pid   = cur_pid;
    assign m_last  = final_pkt;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= cred_rd_pkg::PARSE_IDLE;
        end else begin
            case (state)
                cred_rd_pkg::PARSE_IDLE: begin
                    if (take) begin
                        state <= cred_rd_pkg::PARSE_SPLIT;
                    end
                end
                cred_rd_pkg::PARSE_SPLIT: begin
                    // Back to idle once the tail packet goes
                    if (emit && final_pkt) begin
                        state <= cred_rd_pkg::PARSE_IDLE;
                    end
                end
                default: begin
                    state <= cred_rd_pkg::PARSE_IDLE;
                end
            endcase
        end
    end

    // Latch on accept, then step per packet
    always_ff @(posedge aclk) begin
        if (take) begin
            cur_vaddr <= s_vaddr;
            rem_len   <= s_len;
            cur_pid   <= s_pid;
        end else if (emit && !final_pkt) begin
            cur_vaddr <= cur_vaddr + PKT_STEP;
            rem_len   <= rem_len - PKT_LEN;
        end
    end

endmodule

`default_nettype wire

/* read_path/req_queue.sv */
// Host request queue
`default_nettype none

`include "cred_rd_consts.svh"

module req_queue (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  s_valid,
    output logic                 s_ready,
    input  wire cred_rd_pkg::vaddr_t s_vaddr,
    input  wire cred_rd_pkg::len_t   s_len,
    input  wire cred_rd_pkg::pid_t   s_pid,

    output logic                 m_valid,
    input  wire                  m_ready,
    output cred_rd_pkg::vaddr_t  m_vaddr,
    output cred_rd_pkg::len_t    m_len,
    output cred_rd_pkg::pid_t    m_pid
);

    localparam int AW = $clog2(`CRED_REQ_QDEPTH);

    // Entry storage
    cred_rd_pkg::vaddr_t vaddr_mem [`CRED_REQ_QDEPTH];
    cred_rd_pkg::len_t   len_mem   [`CRED_REQ_QDEPTH];
    cred_rd_pkg::pid_t   pid_mem   [`CRED_REQ_QDEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    // Full queue stalls the host
    assign s_ready = (count != (AW+1)'(`CRED_REQ_QDEPTH));
    assign m_valid = (count != '0);
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;

    // Head entry straight from storage
    assign m_vaddr = vaddr_mem[rd_ptr];
    assign m_len   = len_mem[rd_ptr];
    assign m_pid   = pid_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            vaddr_mem[wr_ptr] <= s_vaddr;
            len_mem[wr_ptr]   <= s_len;
            pid_mem[wr_ptr]   <= s_pid;
        end
    end

    // Pointers wrap on power-of-two depth
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* read_path/req_seq.sv */
// Card request register and data tagger
`default_nettype none

`include "cred_rd_consts.svh"

module req_seq (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  s_valid,
    output logic                 s_ready,
    input  wire cred_rd_pkg::vaddr_t s_vaddr,
    input  wire cred_rd_pkg::len_t   s_len,
    input  wire cred_rd_pkg::pid_t   s_pid,
    input  wire                  s_last,

    output logic                 m_req_valid,
    input  wire                  m_req_ready,
    output cred_rd_pkg::vaddr_t  m_req_vaddr,
    output cred_rd_pkg::len_t    m_req_len,
    output cred_rd_pkg::pid_t    m_req_pid,
    output logic                 m_req_last,

    input  wire                  s_data_valid,
    output logic                 s_data_ready,
    input  wire [`CRED_DATA_BITS-1:0] s_data,
    input  wire                  s_data_last,

    output logic                 tag_valid,
    input  wire                  tag_ready,
    output logic [`CRED_DATA_BITS-1:0] tag_data,
    output logic                 tag_last,
    output cred_rd_pkg::pid_t    tag_pid
);

    localparam int PW = $clog2(`CRED_MAX_CREDITS);

    // Pids of issued packets in card order
    cred_rd_pkg::pid_t pid_mem [`CRED_MAX_CREDITS];

    logic [PW-1:0] pid_wr_ptr;
    logic [PW-1:0] pid_rd_ptr;
    logic [PW:0]   pid_count;
    logic          pid_avail;
    logic          pid_push;
    logic          pid_pop;

    // Output register takes a new request when empty or draining
    assign s_ready = !m_req_valid || m_req_ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_req_valid <= 1'b0;
        end else if (s_ready) begin
            m_req_valid <= s_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            m_req_vaddr <= s_vaddr;
            m_req_len   <= s_len;
            m_req_pid   <= s_pid;
            m_req_last  <= s_last;
        end
    end

    // Credits keep the pid FIFO from overflowing
    assign pid_push  = m_req_valid && m_req_ready;
    assign pid_avail = (pid_count != '0);

    // Card only answers issued requests
    assign s_data_ready = tag_ready;
    assign tag_valid    = s_data_valid && pid_avail;
    assign tag_data     = s_data;
    assign tag_last     = s_data_last;
    assign tag_pid      = pid_mem[pid_rd_ptr];

    // Head retires with its packet's last beat
    assign pid_pop = tag_valid && tag_ready && s_data_last;

    always_ff @(posedge aclk) begin
        if (pid_push) begin
            pid_mem[pid_wr_ptr] <= m_req_pid;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pid_wr_ptr <= '0;
            pid_rd_ptr <= '0;
            pid_count  <= '0;
        end else begin
            if (pid_push) begin
                pid_wr_ptr <= pid_wr_ptr + 1'b1;
            end
            if (pid_pop) begin
                pid_rd_ptr <= pid_rd_ptr + 1'b1;
            end
            if (pid_push && !pid_pop) begin
                pid_count <= pid_count + 1'b1;
            end else if (!pid_push && pid_pop) begin
                pid_count <= pid_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/cred_rd_pkg.sv
read_path/req_queue.sv
read_path/req_parser.sv
read_path/req_credits.sv
read_path/req_seq.sv
read_path/data_fifo.sv
logic/credit_rd_top.sv
test/credit_rd_tb.sv

/* test/credit_rd_tb.sv */
// Credit read path testbench
`default_nettype none

`include "cred_rd_consts.svh"

module credit_rd_tb;

    localparam int NUM_REQ         = 12;
    localparam int PERIOD          = 20;
    localparam int DW              = `CRED_DATA_BITS;
    localparam int WATCHDOG_CYCLES = 200 * NUM_REQ + 1000;
    localparam cred_rd_pkg::len_t   PKT_LEN  = cred_rd_pkg::len_t'(`CRED_PKT_BYTES);
    localparam cred_rd_pkg::vaddr_t PKT_STEP = cred_rd_pkg::vaddr_t'(`CRED_PKT_BYTES);

    typedef struct packed {
        cred_rd_pkg::vaddr_t vaddr;
        cred_rd_pkg::len_t   len;
        cred_rd_pkg::pid_t   pid;
        logic                last;
    } pkt_t;

    typedef struct packed {
        logic [DW-1:0]     data;
        logic              last;
        cred_rd_pkg::pid_t pid;
    } beat_t;

    logic                aclk;
    logic                rst_n;
    logic                s_req_valid;
    logic                s_req_ready;
    cred_rd_pkg::vaddr_t s_req_vaddr;
    cred_rd_pkg::len_t   s_req_len;
    cred_rd_pkg::pid_t   s_req_pid;
    logic                m_req_valid;
    logic                m_req_ready;
    cred_rd_pkg::vaddr_t m_req_vaddr;
    cred_rd_pkg::len_t   m_req_len;
    cred_rd_pkg::pid_t   m_req_pid;
    logic                m_req_last;
    logic                s_data_valid;
    logic                s_data_ready;
    logic [DW-1:0]       s_data;
    logic                s_data_last;
    logic                m_data_valid;
    logic                m_data_ready;
    logic [DW-1:0]       m_data;
    logic                m_data_last;
    cred_rd_pkg::pid_t   m_data_pid;

    // Request table with hand-worked packet and beat counts
    cred_rd_pkg::pid_t   tbl_pid   [NUM_REQ];
    cred_rd_pkg::vaddr_t tbl_vaddr [NUM_REQ];
    cred_rd_pkg::len_t   tbl_len   [NUM_REQ];
    int                  tbl_pkts  [NUM_REQ];
    int                  tbl_beats [NUM_REQ];

    // Scoreboard and card model state
    pkt_t                exp_pkts   [$];
    beat_t               exp_beats  [$];
    cred_rd_pkg::vaddr_t card_addr  [$];
    int                  card_beats [$];
    int                  beat_idx;
    // Card beats accepted at the rising edge, and those the card has moved past
    int                  card_taken;
    int                  card_retired;
    bit                  hold_data_low;
    int                  issued_cnt;
    int                  done_pkts;
    int                  beats_rx;
    int                  err_count;
    int                  test_cnt;
    int                  fail_cnt;
    integer              seed = 32'hd44257cb;

    credit_rd_top uut (
        .aclk(aclk), .rst_n(rst_n),
        .s_req_valid(s_req_valid), .s_req_ready(s_req_ready),
        .s_req_vaddr(s_req_vaddr), .s_req_len(s_req_len), .s_req_pid(s_req_pid),
        .m_req_valid(m_req_valid), .m_req_ready(m_req_ready),
        .m_req_vaddr(m_req_vaddr), .m_req_len(m_req_len),
        .m_req_pid(m_req_pid), .m_req_last(m_req_last),
        .s_data_valid(s_data_valid), .s_data_ready(s_data_ready),
        .s_data(s_data), .s_data_last(s_data_last),
        .m_data_valid(m_data_valid), .m_data_ready(m_data_ready),
        .m_data(m_data), .m_data_last(m_data_last), .m_data_pid(m_data_pid)
    );

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
        err_count++;
    endtask

    task automatic set_row(input int i, input int pid, input int vaddr, input int len,
                           input int pkts, input int beats);
        tbl_pid[i]   = cred_rd_pkg::pid_t'(pid);
        tbl_vaddr[i] = cred_rd_pkg::vaddr_t'(vaddr);
        tbl_len[i]   = cred_rd_pkg::len_t'(len);
        tbl_pkts[i]  = pkts;
        tbl_beats[i] = beats;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_count - errs_before);
        end
    endtask

    // Expected packets and beats per the split rule, then the host handshake
    task automatic send_req(input int row);
        cred_rd_pkg::vaddr_t addr;
        cred_rd_pkg::len_t   rem;
        pkt_t                ep;
        beat_t               eb;
        int                  nbeats;
        addr = tbl_vaddr[row];
        rem  = tbl_len[row];
        while (rem != 0) begin
            ep.vaddr = addr;
            ep.len   = (rem > PKT_LEN) ? PKT_LEN : rem;
            ep.pid   = tbl_pid[row];
            ep.last  = (rem <= PKT_LEN);
            exp_pkts.push_back(ep);
            nbeats = (int'(ep.len) + 7) / 8;
            for (int b = 0; b < nbeats; b++) begin
                eb.data = DW'(addr) + DW'(b);
                eb.last = (b == nbeats - 1);
                eb.pid  = tbl_pid[row];
                exp_beats.push_back(eb);
            end
            addr = addr + PKT_STEP;
            rem  = rem - ep.len;
        end
        @(negedge aclk);
        s_req_valid = 1'b1;
        s_req_vaddr = tbl_vaddr[row];
        s_req_len   = tbl_len[row];
        s_req_pid   = tbl_pid[row];
        do begin
            @(posedge aclk);
        end while (!s_req_ready);
    endtask

    task automatic end_host();
        @(negedge aclk);
        s_req_valid = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_pkts.size() != 0 || exp_beats.size() != 0) && n < limit) begin
            @(negedge aclk);
            n++;
        end
        if (exp_pkts.size() != 0 || exp_beats.size() != 0) begin
            $display("timeout at %0t with %0d packets and %0d beats still missing",
                     $time, exp_pkts.size(), exp_beats.size());
            err_count++;
        end
    endtask

    task automatic wait_issued(input int target, input int limit);
        int n;
        n = 0;
        while (issued_cnt < target && n < limit) begin
            @(negedge aclk);
            n++;
        end
        if (issued_cnt < target) begin
            $display("timeout at %0t, only %0d of %0d card requests issued",
                     $time, issued_cnt, target);
            err_count++;
        end
    endtask

    // Handshake monitor and scoreboard
    always @(posedge aclk) begin
        pkt_t  ep;
        beat_t eb;
        if (rst_n) begin
            if (m_req_valid && m_req_ready) begin
                if (exp_pkts.size() == 0) begin
                    $display("unexpected card request for address %h at %0t",
                             m_req_vaddr, $time);
                    err_count++;
                end else begin
                    ep = exp_pkts.pop_front();
                    if (m_req_vaddr !== ep.vaddr)
                        report_mismatch("m_req_vaddr", 64'(ep.vaddr), 64'(m_req_vaddr));
                    if (m_req_len !== ep.len)
                        report_mismatch("m_req_len", 64'(ep.len), 64'(m_req_len));
                    if (m_req_pid !== ep.pid)
                        report_mismatch("m_req_pid", 64'(ep.pid), 64'(m_req_pid));
                    if (m_req_last !== ep.last)
                        report_mismatch("m_req_last", 64'(ep.last), 64'(m_req_last));
                end
                // Card answers every issued request in order
                card_addr.push_back(m_req_vaddr);
                card_beats.push_back((int'(m_req_len) + 7) / 8);
                issued_cnt++;
                if (issued_cnt - done_pkts > `CRED_MAX_CREDITS) begin
                    $display("more than %0d packets in flight at %0t",
                             `CRED_MAX_CREDITS, $time);
                    err_count++;
                end
            end
            if (s_data_valid && s_data_ready) begin
                card_taken++;
            end
            if (m_data_valid && m_data_ready) begin
                if (exp_beats.size() == 0) begin
                    $display("unexpected data beat %h at %0t", m_data, $time);
                    err_count++;
                end else begin
                    eb = exp_beats.pop_front();
                    if (m_data !== eb.data)
                        report_mismatch("m_data", 64'(eb.data), 64'(m_data));
                    if (m_data_last !== eb.last)
                        report_mismatch("m_data_last", 64'(eb.last), 64'(m_data_last));
                    if (m_data_pid !== eb.pid)
                        report_mismatch("m_data_pid", 64'(eb.pid), 64'(m_data_pid));
                end
                beats_rx++;
                if (m_data_last) begin
                    done_pkts++;
                end
            end
        end
    end

    // Card model and random stalls
    always @(negedge aclk) begin
        if (!rst_n) begin
            s_data_valid = 1'b0;
            beat_idx     = 0;
            card_retired = 0;
        end else begin
            if (card_taken != card_retired) begin
                card_retired++;
                s_data_valid = 1'b0;
                if (beat_idx == card_beats[0] - 1) begin
                    void'(card_addr.pop_front());
                    void'(card_beats.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
            // Gap one cycle in four
            if (!s_data_valid && card_addr.size() != 0 && (($random(seed) & 3) != 0)) begin
                s_data_valid = 1'b1;
                s_data       = DW'(card_addr[0]) + DW'(beat_idx);
                s_data_last  = (beat_idx == card_beats[0] - 1);
            end
            m_req_ready  = (($random(seed) & 3) != 0);
            m_data_ready = (($random(seed) & 3) != 0) && !hold_data_low;
        end
    end

    initial begin
        int errs_before;
        int base_pkts;
        int base_beats;
        int want_pkts;
        int want_beats;
        s_req_valid   = 1'b0;
        s_req_vaddr   = '0;
        s_req_len     = '0;
        s_req_pid     = '0;
        m_req_ready   = 1'b0;
        s_data_valid  = 1'b0;
        s_data        = '0;
        s_data_last   = 1'b0;
        m_data_ready  = 1'b0;
        hold_data_low = 1'b0;
        issued_cnt    = 0;
        done_pkts     = 0;
        beats_rx      = 0;
        err_count     = 0;
        test_cnt      = 0;
        fail_cnt      = 0;
        // Row, pid, vaddr, len, packets, beats
        set_row(0, 1, 'h1000, 1, 1, 1);
        set_row(1, 2, 'h2000, 8, 1, 1);
        set_row(2, 3, 'h3000, 9, 1, 2);
        set_row(3, 4, 'h4000, 32, 1, 4);
        set_row(4, 5, 'h5000, 33, 2, 5);
        set_row(5, 6, 'h6010, 64, 2, 8);
        set_row(6, 7, 'h7004, 65, 3, 9);
        set_row(7, 8, 'h8000, 100, 4, 13);
        set_row(8, 9, 'h9100, 47, 2, 6);
        set_row(9, 10, 'ha000, 96, 3, 12);
        set_row(10, 11, 'hb0f0, 17, 1, 3);
        set_row(11, 15, 'hfff0, 90, 3, 12);

        rst_n = 1'b0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);

        // Idle outputs after reset
        errs_before = err_count;
        if (m_req_valid !== 1'b0) report_mismatch("m_req_valid", 64'(0), 64'(m_req_valid));
        if (m_data_valid !== 1'b0) report_mismatch("m_data_valid", 64'(0), 64'(m_data_valid));
        if (s_req_ready !== 1'b1) report_mismatch("s_req_ready", 64'(1), 64'(s_req_ready));
        if (s_data_ready !== 1'b1) report_mismatch("s_data_ready", 64'(1), 64'(s_data_ready));
        finish_test("reset state", errs_before);

        // One request at a time under random stalls
        for (int r = 0; r < NUM_REQ; r++) begin
            errs_before = err_count;
            base_pkts   = issued_cnt;
            base_beats  = beats_rx;
            send_req(r);
            end_host();
            wait_drained(400);
            if (issued_cnt - base_pkts != tbl_pkts[r])
                report_mismatch("m_req packets", 64'(tbl_pkts[r]), 64'(issued_cnt - base_pkts));
            if (beats_rx - base_beats != tbl_beats[r])
                report_mismatch("m_data beats", 64'(tbl_beats[r]), 64'(beats_rx - base_beats));
            finish_test($sformatf("request pid %0d len %0d", tbl_pid[r], tbl_len[r]),
                        errs_before);
        end

        // Output held off, issuing stops at the credit limit
        errs_before   = err_count;
        base_pkts     = issued_cnt;
        base_beats    = beats_rx;
        hold_data_low = 1'b1;
        send_req(7);
        send_req(9);
        end_host();
        wait_issued(base_pkts + `CRED_MAX_CREDITS, 200);
        repeat (60) @(negedge aclk);
        if (issued_cnt - base_pkts != `CRED_MAX_CREDITS)
            report_mismatch("m_req packets", 64'(`CRED_MAX_CREDITS), 64'(issued_cnt - base_pkts));
        if (m_req_valid !== 1'b0) report_mismatch("m_req_valid", 64'(0), 64'(m_req_valid));
        hold_data_low = 1'b0;
        wait_drained(400);
        want_pkts  = tbl_pkts[7] + tbl_pkts[9];
        want_beats = tbl_beats[7] + tbl_beats[9];
        if (issued_cnt - base_pkts != want_pkts)
            report_mismatch("m_req packets", 64'(want_pkts), 64'(issued_cnt - base_pkts));
        if (beats_rx - base_beats != want_beats)
            report_mismatch("m_data beats", 64'(want_beats), 64'(beats_rx - base_beats));
        finish_test("credit limit", errs_before);

        // Whole table back to back
        errs_before = err_count;
        base_pkts   = issued_cnt;
        base_beats  = beats_rx;
        want_pkts   = 0;
        want_beats  = 0;
        for (int r = 0; r < NUM_REQ; r++) begin
            send_req(r);
            want_pkts  = want_pkts + tbl_pkts[r];
            want_beats = want_beats + tbl_beats[r];
        end
        end_host();
        wait_drained(100 * NUM_REQ);
        if (issued_cnt - base_pkts != want_pkts)
            report_mismatch("m_req packets", 64'(want_pkts), 64'(issued_cnt - base_pkts));
        if (beats_rx - base_beats != want_beats)
            report_mismatch("m_data beats", 64'(want_beats), 64'(beats_rx - base_beats));
        finish_test("back to back burst", errs_before);

        $display("tests %0d, failing %0d, errors %0d, packets %0d, beats %0d",
                 test_cnt, fail_cnt, err_count, issued_cnt, beats_rx);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run length bound from the table size
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("watchdog expired after %0d cycles, simulation stuck", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
